// File: rtl/ifetch_pkg.sv
package ifetch_pkg;

    // byte address width of the fetch path
    localparam int ADDR_W = 32;

    // one instruction word per fetch
    localparam int DATA_W = 32;

    // cache controller states
    //   CACHE_IDLE     waits for a fetch request and runs the valid sweep after reset
    //   CACHE_COMPARE  checks the captured tag and answers on a hit
    //   CACHE_ALLOCATE waits on the instruction memory and fills the line
    // instruction lines are never written by the core, so there is no write-back state
    typedef enum logic [1:0] {
        CACHE_IDLE     = 2'd0,
        CACHE_COMPARE  = 2'd1,
        CACHE_ALLOCATE = 2'd2
    } cache_state_e;

endpackage

// File: rtl/fetch_if.sv
`timescale 1ns/10ps

interface fetch_if;

    // request side, owned by the fetch unit
    logic                          req_valid; // level, held until resp_ready
    logic [ifetch_pkg::ADDR_W-1:0] req_addr;  // stable while req_valid is high

    // response side, owned by the cache
    logic                          resp_ready; // one-cycle strobe
    logic [ifetch_pkg::DATA_W-1:0] resp_data;  // valid together with resp_ready

    modport requester (
        output req_valid,
        output req_addr,
        input  resp_ready,
        input  resp_data
    );

    modport responder (
        input  req_valid,
        input  req_addr,
        output resp_ready,
        output resp_data
    );

endinterface

// File: rtl/fetch_unit.sv
`timescale 1ns/10ps

module fetch_unit #(
    parameter logic [ifetch_pkg::ADDR_W-1:0] RESET_PC = '0
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          redirect_valid,
    input  logic [ifetch_pkg::ADDR_W-1:0] redirect_pc,
    input  logic                          fetch_hold,
    fetch_if.requester                    cache,
    output logic                          instr_valid,
    output logic [ifetch_pkg::DATA_W-1:0] instr,
    output logic [ifetch_pkg::ADDR_W-1:0] instr_pc
);

    logic [ifetch_pkg::ADDR_W-1:0] pc;         // address of the next request to issue
    logic [ifetch_pkg::ADDR_W-1:0] pc_next;
    logic [ifetch_pkg::ADDR_W-1:0] req_addr_q; // address of the outstanding request
    logic                          pending;    // a request is out at the cache
    logic                          discard;    // the outstanding response is stale
    logic                          resp_done;
    logic                          accept;
    logic                          issue;

    assign resp_done = pending && cache.resp_ready;

    // a response is only used if no redirect came since it was issued
    assign accept = resp_done && !discard && !redirect_valid;

    // one request at a time, the next one goes out right after the response
    assign issue = (!pending || resp_done) && !fetch_hold;

    always_comb
    begin
        pc_next = pc;
        if (redirect_valid)
        begin
            pc_next = redirect_pc;
        end
        else if (accept)
        begin
            pc_next = req_addr_q + ifetch_pkg::ADDR_W'(4);
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            pc          <= RESET_PC;
            pending     <= 1'b0;
            discard     <= 1'b0;
            instr_valid <= 1'b0;
        end
        else
        begin
            pc          <= pc_next;
            instr_valid <= accept;
            if (issue)
            begin
                pending <= 1'b1;
            end
            else if (resp_done)
            begin
                pending <= 1'b0;
            end
            // the stale response still arrives, it is dropped here and not shown
            if (resp_done)
            begin
                discard <= 1'b0;
            end
            else if (redirect_valid && pending)
            begin
                discard <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (issue)
        begin
            req_addr_q <= pc_next;
        end
        if (accept)
        begin
            instr    <= cache.resp_data;
            instr_pc <= req_addr_q;
        end
    end

    // the request is kept up until the cache answers, even when it went stale
    assign cache.req_valid = pending;
    assign cache.req_addr  = req_addr_q;

endmodule

// File: rtl/icache.sv
`timescale 1ns/10ps

module icache #(
    parameter int CACHE_SETS = 16
) (
    input  logic                          clk,
    input  logic                          rst,
    fetch_if.responder                    core,
    output logic                          mem_req_valid,
    output logic [ifetch_pkg::ADDR_W-1:0] mem_req_addr,
    input  logic                          mem_ready,
    input  logic [ifetch_pkg::DATA_W-1:0] mem_data,
    output logic [31:0]                   hit_count,
    output logic [31:0]                   miss_count
);

    // one word per line, so the index sits right above the byte offset
    localparam int INDEX_W = $clog2(CACHE_SETS);
    localparam int TAG_W   = ifetch_pkg::ADDR_W - INDEX_W - 2;

    ifetch_pkg::cache_state_e state;
    ifetch_pkg::cache_state_e state_next;

    logic [CACHE_SETS-1:0]         valid;
    logic [TAG_W-1:0]              tag_mem  [CACHE_SETS];
    logic [ifetch_pkg::DATA_W-1:0] data_mem [CACHE_SETS];

    logic [ifetch_pkg::ADDR_W-1:0] req_addr_q; // request captured in idle
    logic [INDEX_W-1:0]            req_index;
    logic [TAG_W-1:0]              req_tag;
    logic                          allocated;  // this request went through a fill

    logic                          sweep_active;
    logic [INDEX_W-1:0]            sweep_idx;

    logic                          accept_req;
    logic                          hit;
    logic                          fill;

    assign req_index = req_addr_q[INDEX_W+1:2];
    assign req_tag   = req_addr_q[ifetch_pkg::ADDR_W-1:INDEX_W+2];

    // no request is taken while the valid bits are still being cleared
    assign accept_req = (state == ifetch_pkg::CACHE_IDLE) && !sweep_active && core.req_valid;

    assign hit  = valid[req_index] && (tag_mem[req_index] == req_tag);
    assign fill = (state == ifetch_pkg::CACHE_ALLOCATE) && mem_ready;

    always_comb
    begin
        state_next = state;
        case (state)
            ifetch_pkg::CACHE_IDLE:
            begin
                if (accept_req)
                begin
                    state_next = ifetch_pkg::CACHE_COMPARE;
                end
            end
            ifetch_pkg::CACHE_COMPARE:
            begin
                if (hit)
                begin
                    state_next = ifetch_pkg::CACHE_IDLE;
                end
                else
                begin
                    state_next = ifetch_pkg::CACHE_ALLOCATE;
                end
            end
            ifetch_pkg::CACHE_ALLOCATE:
            begin
                // after the fill the compare runs again and hits
                if (mem_ready)
                begin
                    state_next = ifetch_pkg::CACHE_COMPARE;
                end
            end
            default:
            begin
                state_next = ifetch_pkg::CACHE_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state        <= ifetch_pkg::CACHE_IDLE;
            allocated    <= 1'b0;
            sweep_active <= 1'b1;
            sweep_idx    <= '0;
            hit_count    <= '0;
            miss_count   <= '0;
        end
        else
        begin
            state <= state_next;
            if (sweep_active)
            begin
                sweep_idx <= sweep_idx + 1'b1;
                if (sweep_idx == INDEX_W'(CACHE_SETS - 1))
                begin
                    sweep_active <= 1'b0;
                end
            end
            if (accept_req)
            begin
                allocated <= 1'b0;
            end
            else if (state == ifetch_pkg::CACHE_COMPARE && !hit)
            begin
                allocated <= 1'b1;
            end
            // a refilled line answers through compare too, but only counts as a miss
            if (state == ifetch_pkg::CACHE_COMPARE && hit && !allocated)
            begin
                hit_count <= hit_count + 32'd1;
            end
            if (state == ifetch_pkg::CACHE_COMPARE && !hit)
            begin
                miss_count <= miss_count + 32'd1;
            end
        end
    end

    // valid bits are cleared one line per cycle by the sweep after reset
    always_ff @(posedge clk)
    begin
        if (sweep_active)
        begin
            valid[sweep_idx] <= 1'b0;
        end
        else if (fill)
        begin
            valid[req_index] <= 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (accept_req)
        begin
            req_addr_q <= core.req_addr;
        end
        if (fill)
        begin
            tag_mem[req_index]  <= req_tag;
            data_mem[req_index] <= mem_data;
        end
    end

    assign core.resp_ready = (state == ifetch_pkg::CACHE_COMPARE) && hit;
    assign core.resp_data  = data_mem[req_index];

    // word aligned request, held until mem_ready
    assign mem_req_valid = (state == ifetch_pkg::CACHE_ALLOCATE);
    assign mem_req_addr  = {req_addr_q[ifetch_pkg::ADDR_W-1:2], 2'b00};

endmodule

// File: rtl/ifetch_top.sv
`timescale 1ns/10ps

module ifetch_top #(
    parameter int                            CACHE_SETS = 16,
    parameter logic [ifetch_pkg::ADDR_W-1:0] RESET_PC   = '0
) (
    input  logic                          clk,
    input  logic                          rst,

    input  logic                          redirect_valid,
    input  logic [ifetch_pkg::ADDR_W-1:0] redirect_pc,
    input  logic                          fetch_hold,
    output logic                          instr_valid,
    output logic [ifetch_pkg::DATA_W-1:0] instr,
    output logic [ifetch_pkg::ADDR_W-1:0] instr_pc,

    output logic                          mem_req_valid,
    output logic [ifetch_pkg::ADDR_W-1:0] mem_req_addr,
    input  logic                          mem_ready,
    input  logic [ifetch_pkg::DATA_W-1:0] mem_data,

    output logic [31:0]                   hit_count,
    output logic [31:0]                   miss_count
);

    fetch_if fetch_bus ();

    fetch_unit #(
        .RESET_PC (RESET_PC)
    ) u_fetch_unit (
        .clk            (clk),
        .rst            (rst),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .fetch_hold     (fetch_hold),
        .cache          (fetch_bus.requester),
        .instr_valid    (instr_valid),
        .instr          (instr),
        .instr_pc       (instr_pc)
    );

    icache #(
        .CACHE_SETS (CACHE_SETS)
    ) u_icache (
        .clk           (clk),
        .rst           (rst),
        .core          (fetch_bus.responder),
        .mem_req_valid (mem_req_valid),
        .mem_req_addr  (mem_req_addr),
        .mem_ready     (mem_ready),
        .mem_data      (mem_data),
        .hit_count     (hit_count),
        .miss_count    (miss_count)
    );

endmodule

// File: sim/imem_model.sv
`timescale 1ns/10ps

module imem_model #(
    parameter logic [31:0] SEED = 32'd99285
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          mem_req_valid,
    input  logic [ifetch_pkg::ADDR_W-1:0] mem_req_addr,
    output logic                          mem_ready,
    output logic [ifetch_pkg::DATA_W-1:0] mem_data,
    output logic [31:0]                   req_count,
    output logic                          addr_error
);

    logic        busy       = 1'b0;
    logic        ready_q    = 1'b0;
    logic [31:0] data_q     = '0;
    logic [2:0]  wait_cnt   = '0;
    logic [31:0] addr_q     = '0;
    logic [31:0] rng        = SEED;
    logic [31:0] count_q    = '0;
    logic        addr_err_q = 1'b0;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // instruction word stored at a byte address
    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        logic [31:0] x;
        x = addr ^ 32'h5a5a_0000;
        return {x[24:0], x[31:25]};
    endfunction

    always @(posedge clk)
    begin
        if (rst)
        begin
            busy       <= 1'b0;
            ready_q    <= 1'b0;
            wait_cnt   <= '0;
            rng        <= SEED;
            count_q    <= '0;
            addr_err_q <= 1'b0;
        end
        else
        begin
            ready_q <= 1'b0;
            if (ready_q)
            begin
                busy <= 1'b0;
            end
            else if (busy)
            begin
                if (!mem_req_valid || mem_req_addr != addr_q)
                begin
                    addr_err_q <= 1'b1; // request dropped or moved before mem_ready
                end
                if (wait_cnt == 3'd0)
                begin
                    ready_q <= 1'b1;
                    data_q  <= mem_word(addr_q);
                end
                else
                begin
                    wait_cnt <= wait_cnt - 3'd1;
                end
            end
            else if (mem_req_valid)
            begin
                busy     <= 1'b1;
                addr_q   <= mem_req_addr;
                rng      <= lcg_next(rng);
                wait_cnt <= 3'((lcg_next(rng) >> 16) % 32'd6); // 1 to 6 cycles of latency
                count_q  <= count_q + 32'd1;
            end
        end
    end

    assign mem_ready  = ready_q;
    assign mem_data   = data_q;
    assign req_count  = count_q;
    assign addr_error = addr_err_q;

endmodule

// File: sim/tb_ifetch.sv
`timescale 1ns/10ps

module tb_ifetch;

    localparam int CACHE_SETS  = 16;
    localparam int NUM_TESTS   = 6;
    localparam int RUN_TIMEOUT = 1000; // cycles for one table row
    localparam int QUIET_LIMIT = 200;

    typedef struct packed {
        logic [31:0] start_pc;
        logic        cut_en;   // redirect again once the first miss is outstanding
        logic [31:0] cut_pc;
        int          hold_at;  // instructions seen before fetch_hold goes high
        int          hold_len;
        int          count;
        int          d_hit;
        int          d_miss;
    } test_row_t;

    logic                          clk            = 1'b0;
    logic                          rst            = 1'b1;
    logic                          redirect_valid = 1'b0;
    logic [ifetch_pkg::ADDR_W-1:0] redirect_pc    = '0;
    logic                          fetch_hold     = 1'b1;
    logic                          instr_valid;
    logic [ifetch_pkg::DATA_W-1:0] instr;
    logic [ifetch_pkg::ADDR_W-1:0] instr_pc;
    logic                          mem_req_valid;
    logic [ifetch_pkg::ADDR_W-1:0] mem_req_addr;
    logic                          mem_ready;
    logic [ifetch_pkg::DATA_W-1:0] mem_data;
    logic [31:0]                   hit_count;
    logic [31:0]                   miss_count;
    logic [31:0]                   mem_requests;
    logic                          mem_addr_error;

    test_row_t rows [NUM_TESTS];
    string     row_name [NUM_TESTS];
    int        checks       = 0;
    int        errors       = 0;
    int        tests_failed = 0;

    always #2 clk = ~clk;

    ifetch_top #(
        .CACHE_SETS (CACHE_SETS),
        .RESET_PC   (32'h0000_0000)
    ) u_ifetch_top (
        .clk            (clk),
        .rst            (rst),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .fetch_hold     (fetch_hold),
        .instr_valid    (instr_valid),
        .instr          (instr),
        .instr_pc       (instr_pc),
        .mem_req_valid  (mem_req_valid),
        .mem_req_addr   (mem_req_addr),
        .mem_ready      (mem_ready),
        .mem_data       (mem_data),
        .hit_count      (hit_count),
        .miss_count     (miss_count)
    );

    imem_model u_imem_model (
        .clk           (clk),
        .rst           (rst),
        .mem_req_valid (mem_req_valid),
        .mem_req_addr  (mem_req_addr),
        .mem_ready     (mem_ready),
        .mem_data      (mem_data),
        .req_count     (mem_requests),
        .addr_error    (mem_addr_error)
    );

    // word the memory holds at a byte address
    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        logic [31:0] x;
        x = addr ^ 32'h5a5a_0000;
        return {x[24:0], x[31:25]};
    endfunction

    task automatic check_value(input string test, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (actual !== expected)
        begin
            $display("Mismatch %s expected 0x%08h actual 0x%08h", test, expected, actual);
            errors++;
        end
    endtask

    task automatic load_table();
        // start_pc, cut_en, cut_pc, hold_at, hold_len, count, d_hit, d_miss
        rows[0] = '{32'h0000_0000, 1'b0, 32'h0, 0, 0, 8, 0, 8};
        rows[1] = '{32'h0000_0000, 1'b0, 32'h0, 0, 0, 8, 8, 0};
        rows[2] = '{32'(4 * CACHE_SETS), 1'b0, 32'h0, 0, 0, 8, 0, 8}; // same indexes, new tag
        rows[3] = '{32'h0000_0000, 1'b0, 32'h0, 0, 0, 8, 0, 8};
        rows[4] = '{32'h0000_1000, 1'b1, 32'h0000_0020, 0, 0, 4, 0, 5}; // stale miss still fills
        rows[5] = '{32'h0000_0020, 1'b0, 32'h0, 4, 20, 12, 4, 8};
        row_name[0] = "cold_run";
        row_name[1] = "warm_refetch";
        row_name[2] = "alias_evict";
        row_name[3] = "return_evicted";
        row_name[4] = "redirect_on_miss";
        row_name[5] = "hold_mid_run";
    endtask

    task automatic report_test(input string test, input int err_before);
        if (errors == err_before)
        begin
            $display("test %-18s passed", test);
        end
        else
        begin
            tests_failed++;
            $display("test %-18s failed with %0d errors", test, errors - err_before);
        end
    endtask

    task automatic wait_quiet(input string test);
        int quiet;
        int cycles;
        quiet  = 0;
        cycles = 0;
        while (quiet < 8 && cycles < QUIET_LIMIT)
        begin
            @(negedge clk);
            cycles++;
            quiet = (instr_valid || mem_req_valid) ? 0 : quiet + 1;
        end
        if (quiet < 8)
        begin
            $display("%s: fetch path still busy after %0d cycles", test, QUIET_LIMIT);
            errors++;
        end
    endtask

    task automatic check_reset_idle();
        int err_before;
        err_before = errors;
        repeat (40)
        begin
            @(negedge clk);
            check_value("reset_idle", 32'd0, 32'(instr_valid));
            check_value("reset_idle", 32'd0, 32'(mem_req_valid));
            check_value("reset_idle", 32'd0, hit_count);
            check_value("reset_idle", 32'd0, miss_count);
        end
        report_test("reset_idle", err_before);
    endtask

    task automatic run_row(input int i);
        test_row_t   row;
        string       name;
        logic [31:0] exp_pc;
        logic [31:0] hit0;
        logic [31:0] miss0;
        logic [31:0] req0;
        int          got;
        int          cycles;
        int          hold_left;
        int          hold_seen;
        int          err_before;
        logic        in_hold;
        logic        hold_done;
        logic        cut_done;
        row        = rows[i];
        name       = row_name[i];
        err_before = errors;
        wait_quiet(name);
        hit0      = hit_count;
        miss0     = miss_count;
        req0      = mem_requests;
        exp_pc    = row.cut_en ? row.cut_pc : row.start_pc;
        got       = 0;
        cycles    = 0;
        hold_left = 0;
        hold_seen = 0;
        in_hold   = 1'b0;
        hold_done = 1'b0;
        cut_done  = !row.cut_en;
        @(negedge clk);
        redirect_valid = 1'b1;
        redirect_pc    = row.start_pc;
        while (got < row.count && cycles < RUN_TIMEOUT)
        begin
            @(negedge clk);
            cycles++;
            redirect_valid = 1'b0;
            if (instr_valid)
            begin
                check_value(name, exp_pc, instr_pc);
                check_value(name, mem_word(exp_pc), instr);
                hold_seen = in_hold ? hold_seen + 1 : hold_seen;
                exp_pc = exp_pc + 32'd4;
                got++;
            end
            if (!cut_done && mem_req_valid)
            begin
                redirect_valid = 1'b1;
                redirect_pc    = row.cut_pc;
                cut_done       = 1'b1;
            end
            if (in_hold)
            begin
                hold_left--;
                in_hold = (hold_left > 0);
                if (!in_hold && hold_seen > 1)
                begin
                    check_value(name, 32'd1, 32'(hold_seen)); // only the outstanding word
                end
            end
            else if (!hold_done && row.hold_len != 0 && got == row.hold_at)
            begin
                in_hold   = 1'b1;
                hold_done = 1'b1;
                hold_left = row.hold_len;
            end
            // holding from the next to last word on lets exactly count requests out
            fetch_hold = in_hold || (got >= row.count - 1);
        end
        fetch_hold     = 1'b1;
        redirect_valid = 1'b0;
        if (got < row.count)
        begin
            $display("%s: timed out with %0d of %0d instructions", name, got, row.count);
            errors++;
        end
        repeat (12)
        begin
            @(negedge clk);
            if (instr_valid)
            begin
                $display("%s: extra instruction at 0x%08h after the run", name, instr_pc);
                errors++;
            end
        end
        check_value(name, 32'(row.d_hit), hit_count - hit0);
        check_value(name, 32'(row.d_miss), miss_count - miss0);
        check_value(name, 32'(row.d_miss), mem_requests - req0);
        check_value(name, 32'd0, 32'(mem_addr_error));
        report_test(name, err_before);
    endtask

    initial
    begin
        load_table();
        repeat (8) @(negedge clk);
        rst = 1'b0;
        check_reset_idle();
        for (int i = 0; i < NUM_TESTS; i++)
        begin
            run_row(i);
        end
        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 NUM_TESTS + 1, tests_failed, checks, errors);
        if (errors == 0)
        begin
            $display("Everything OK");
        end
        else
        begin
            $display("Something failed");
        end
        $finish;
    end

    initial
    begin
        #200000;
        $display("simulation time limit reached before the tests finished");
        $display("Something failed");
        $finish;
    end

endmodule

// File: ifetch.f
rtl/ifetch_pkg.sv
rtl/fetch_if.sv
rtl/fetch_unit.sv
rtl/icache.sv
rtl/ifetch_top.sv
sim/imem_model.sv
sim/tb_ifetch.sv

// File: Makefile
# Verilator build and run for the instruction fetch testbench

VERILATOR ?= verilator
FILELIST  ?= ifetch.f
TOP       ?= tb_ifetch
RTL_TOP   ?= ifetch_top
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
LINTFLAGS ?= --lint-only -Wall --timing
PASS_MSG  ?= Everything OK

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# the simulation passes only if the pass message shows up in its output
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR)
